// ==== filelist.f ====
+incdir+tests
hdl/tetris_render_pkg.sv
hdl/board_if.sv
hdl/board_regs.sv
hdl/screen_layout.sv
hdl/pixel_shader.sv
hdl/tetris_renderer.sv
tests/tb_tetris_renderer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_tetris_renderer \
    -f filelist.f

# The log decides the result, so a failing run must not stop the script here
./obj_dir/Vtb_tetris_renderer > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tests/render_model.svh ====
`ifndef RENDER_MODEL_SVH
`define RENDER_MODEL_SVH

// Shadow of the board registers that follows every APB write of the driver
logic [2:0] sh_cells [22][10];
logic [2:0] sh_next;
logic [2:0] sh_hold;
logic       sh_used;
logic       sh_over;

// Piece colours I J L O S T Z, then empty
localparam logic [11:0] model_color [8] = '{
    12'hF00, 12'h0F0, 12'h00F, 12'hFF0, 12'hF0F, 12'h0FF, 12'hFA0, 12'h000
};

// Spawn shapes, bit r*4+c
localparam logic [15:0] model_mask [8] = '{
    16'h00F0,  // I  ....|XXXX
    16'h0071,  // J  X...|XXX.
    16'h0074,  // L  ..X.|XXX.
    16'h0066,  // O  .XX.|.XX.
    16'h0036,  // S  .XX.|XX..
    16'h0072,  // T  .X..|XXX.
    16'h0063,  // Z  XX..|.XX.
    16'h0000
};

task automatic clear_shadow();
    for (int r = 0; r < 22; r++) begin
        for (int c = 0; c < 10; c++) begin
            sh_cells[r][c] = 3'd7;
        end
    end
    sh_next = 3'd7;
    sh_hold = 3'd7;
    sh_used = 1'b0;
    sh_over = 1'b0;
endtask

// 0 unmapped, 1 cell, 2 status word
function automatic int addr_kind(input logic [10:0] addr);
    logic [8:0] word;
    word = addr[10:2];
    if (word == 9'h1F0) return 2;
    if (word[8:4] < 22 && word[3:0] < 10) return 1;
    return 0;
endfunction

task automatic record_write(input logic [10:0] addr, input logic [31:0] data);
    logic [8:0] word;
    word = addr[10:2];
    case (addr_kind(addr))
        1: sh_cells[word[8:4]][word[3:0]] = data[2:0];
        2: begin
            sh_next = data[2:0];
            sh_hold = data[6:4];
            sh_used = data[8];
            sh_over = data[9];
        end
        default: ;  // Ignored
    endcase
endtask

task automatic expected_read(input logic [10:0] addr, output logic [31:0] data,
                             output bit err);
    logic [8:0] word;
    word = addr[10:2];
    data = 32'd0;
    err  = addr_kind(addr) == 0;
    if (addr_kind(addr) == 1) data = {29'd0, sh_cells[word[8:4]][word[3:0]]};
    if (addr_kind(addr) == 2) data = {22'd0, sh_over, sh_used, 1'b0, sh_hold, 1'b0, sh_next};
endtask

// Mask bit test at an offset from the preview piece origin
function automatic bit in_piece(input logic [2:0] code, input int dx, input int dy);
    if (dx < 0 || dx >= 128 || dy < 0 || dy >= 128) return 1'b0;
    return model_mask[code][(dy / 32) * 4 + dx / 32];
endfunction

function automatic logic [11:0] pixel_color(input int x, input int y, input bit act,
                                            output logic [7:0] texel);
    logic [11:0] c;
    logic [2:0]  code;
    bit          piece;
    int          dx;
    int          dy;
    texel = 8'h00;
    c     = 12'h000;
    piece = 1'b0;
    dx    = 0;
    dy    = 0;
    if (!act || x >= 1280 || y >= 800) return 12'h000;
    if (x >= 476 && x < 804 && y >= 76 && y < 724) begin  // Field plus border
        if (x < 480 || x >= 800 || y < 80 || y >= 720) return 12'hFFF;
        dx   = x - 480;
        dy   = y - 80;
        code = sh_cells[dy / 32 + 2][dx / 32];               // Skip spawn rows
        if (code != 3'd7) begin
            piece = 1'b1;
            c     = sh_over ? 12'h666 : model_color[code];
        end else if (dx % 32 == 0 || dx % 32 == 31 || dy % 32 == 0 || dy % 32 == 31) begin
            c = 12'h222;
        end
    end else if (x >= 850 && x < 1000 && y >= 80 && y < 230) begin
        if (y < 100) return 12'hFFF;
        dx = x - 870;
        dy = y - 120;
        if (sh_next != 3'd7 && in_piece(sh_next, dx, dy)) begin
            piece = 1'b1;
            c     = model_color[sh_next];
        end
    end else if (x >= 280 && x < 430 && y >= 80 && y < 230) begin
        if (y < 100) return sh_used ? 12'h555 : 12'h0FF;
        dx = x - 300;
        dy = y - 120;
        if (sh_hold != 3'd7 && in_piece(sh_hold, dx, dy)) begin
            piece = 1'b1;
            c     = sh_used ? 12'h555 : model_color[sh_hold];
        end
    end
    if (piece) begin
        texel = {4'((dx % 32) / 2), 4'((dy % 32) / 2)};  // Block offset halved
        // Odd texels are dim in the ROM model
        if (texel[4] || texel[0]) begin
            c = (c >> 1) & 12'h777;
        end
    end
    return c;
endfunction

`endif

// ==== tests/tb_tetris_renderer.sv ====
`timescale 1ns/1ps

module tb_tetris_renderer;

    localparam int clk_period = 40;
    localparam int n_rand_wr  = 40;
    localparam int n_bad      = 16;
    localparam int n_rand_px  = 400;
    localparam int n_field_px = 600;
    localparam int n_stream   = 3000;
    localparam logic [10:0] status_addr = 11'h7C0;
    // Watchdog budget of three cycles per APB transfer and one per pixel
    localparam int n_apb = 2 * n_rand_wr + 16 + 2 * n_bad + 3 * 221 + 6;
    localparam int n_px  = 340 * 652 + n_rand_px + 328 * 40 + 2 * n_field_px +
                           4 * 2 * 150 * 150 + n_stream;

    logic        clk;
    logic        arst_n;
    logic [10:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [10:0] curr_x;
    logic [9:0]  curr_y;
    logic        active_area;
    logic [3:0]  sprite_addr_x;
    logic [3:0]  sprite_addr_y;
    logic [11:0] sprite_pixel;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;

    int          seed = 68702;
    logic [11:0] exp_q [$];     // Expected colours of pixels in flight
    logic [7:0]  texel_q [$];   // Expected sprite addresses, x then y

    `include "render_model.svh"

    tetris_renderer tetris_renderer_i (.*);

    // Block sprite ROM with the intensity in bits 7:4
    assign sprite_pixel = {sprite_addr_x,
                           (!sprite_addr_x[0] && !sprite_addr_y[0]) ? 4'hF : 4'h7,
                           sprite_addr_y};

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [10:0] cell_addr(input int row, input int col);
        return 11'((row * 16 + col) * 4);
    endfunction

    task automatic apb_xfer(input logic [10:0] addr, input bit wr, input logic [31:0] data);
        logic [31:0] exp_data;
        bit          exp_err;
        expected_read(addr, exp_data, exp_err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);   // Mid access cycle
        assert (pready) else stop_with_error("pready was low during an APB access");
        assert (pslverr === exp_err) else stop_with_error($sformatf(
            "mismatch at %0t ns: pslverr expected %b got %b", $time, exp_err, pslverr));
        if (!wr) begin
            assert (prdata === exp_data) else stop_with_error($sformatf(
                "mismatch at %0t ns: prdata expected %h got %h", $time, exp_data, prdata));
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        if (wr) record_write(addr, data);
    endtask

    task automatic check_rgb(input logic [11:0] exp);
        logic [11:0] got;
        got = {vga_r, vga_g, vga_b};
        assert (got === exp) else stop_with_error($sformatf(
            "mismatch at %0t ns: vga_rgb expected %h got %h", $time, exp, got));
    endtask

    task automatic check_texel(input logic [7:0] exp);
        logic [7:0] got;
        got = {sprite_addr_x, sprite_addr_y};
        assert (got === exp) else stop_with_error($sformatf(
            "mismatch at %0t ns: sprite_addr_x/sprite_addr_y expected %h got %h",
            $time, exp, got));
    endtask

    // Output after edge k+2 is read on the third falling edge after the drive
    task automatic drive_pixel(input int x, input int y, input bit act);
        logic [11:0] rgb;
        logic [7:0]  texel;
        @(negedge clk);
        if (exp_q.size() == 3) check_rgb(exp_q.pop_front());
        // Sprite address belongs to the pixel in stage two
        if (texel_q.size() == 2) check_texel(texel_q.pop_front());
        curr_x      = 11'(x);
        curr_y      = 10'(y);
        active_area = act;
        rgb         = pixel_color(x, y, act, texel);
        exp_q.push_back(rgb);
        texel_q.push_back(texel);
    endtask

    task automatic drain();
        repeat (3) drive_pixel(0, 0, 1'b0);
    endtask

    task automatic scan_rect(input int x0, input int x1, input int y0, input int y1);
        for (int y = y0; y < y1; y++) begin
            for (int x = x0; x < x1; x++) begin
                drive_pixel(x, y, 1'b1);
            end
        end
    endtask

    task automatic fill_field(input bit random_codes);
        for (int r = 0; r < 22; r++) begin
            for (int c = 0; c < 10; c++) begin
                apb_xfer(cell_addr(r, c), 1'b1, random_codes ? 32'(rand_below(8)) : 32'd7);
            end
        end
    endtask

    task automatic random_field_pixels(input int n);
        repeat (n) drive_pixel(476 + rand_below(328), 76 + rand_below(648), 1'b1);
    endtask

    initial begin
        #((3 * n_apb + n_px + 200) * clk_period * 2);
        stop_with_error("watchdog expired before the tests finished");
    end

    initial begin
        logic [10:0] addr;
        int          nxt;
        int          hld;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        curr_x      = '0;
        curr_y      = '0;
        active_area = 1'b0;
        arst_n      = 1'b0;
        clear_shadow();
        repeat (4) @(negedge clk);
        check_rgb(12'h000);
        arst_n = 1'b1;
        @(negedge clk);
        check_rgb(12'h000);

        // Register access and error decode
        repeat (n_rand_wr) begin
            addr = cell_addr(rand_below(22), rand_below(10));
            apb_xfer(addr, 1'b1, $random(seed));
            apb_xfer(addr, 1'b0, 32'd0);
        end
        repeat (8) begin
            apb_xfer(status_addr, 1'b1, $random(seed));
            apb_xfer(status_addr, 1'b0, 32'd0);
        end
        repeat (n_bad) begin
            addr = 11'(rand_below(512) * 4);
            while (addr_kind(addr) != 0) addr = 11'(rand_below(512) * 4);
            apb_xfer(addr, 1'b1, $random(seed));
            apb_xfer(addr, 1'b0, 32'd0);
        end
        for (int r = 0; r < 22; r++) begin
            for (int c = 0; c < 10; c++) begin
                apb_xfer(cell_addr(r, c), 1'b0, 32'd0);  // Bad writes left no trace
            end
        end
        apb_xfer(status_addr, 1'b0, 32'd0);

        // Empty board
        fill_field(1'b0);
        apb_xfer(status_addr, 1'b1, 32'h077);
        scan_rect(470, 810, 74, 726);
        repeat (n_rand_px) drive_pixel(rand_below(1300), rand_below(850), rand_below(2) == 1);
        drain();

        // Filled board including the hidden rows
        fill_field(1'b1);
        scan_rect(476, 804, 76, 116);
        random_field_pixels(n_field_px);
        drain();
        apb_xfer(status_addr, 1'b1, 32'h277);
        random_field_pixels(n_field_px);
        drain();

        // Preview boxes with an empty hold piece on the third pass
        for (int p = 0; p < 4; p++) begin
            nxt = rand_below(7);
            hld = (p == 2) ? 7 : rand_below(7);
            apb_xfer(status_addr, 1'b1, 32'(((p % 2) << 8) | (hld << 4) | nxt));
            scan_rect(850, 1000, 80, 230);
            scan_rect(280, 430, 80, 230);
            drain();
        end

        // Back to back stream
        repeat (n_stream) begin
            drive_pixel(260 + rand_below(800), 60 + rand_below(700), rand_below(8) != 0);
        end
        drain();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== hdl/tetris_renderer.sv ====
`timescale 1ns/1ps

module tetris_renderer (
    input  logic                                    clk,
    input  logic                                    arst_n,
    // APB slave
    input  logic [tetris_render_pkg::apb_addr_w-1:0] paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [31:0]                             pwdata,
    output logic [31:0]                             prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    // Pixel stream in
    input  logic [10:0]                             curr_x,
    input  logic [9:0]                              curr_y,
    input  logic                                    active_area,
    // Block sprite ROM
    output logic [3:0]                              sprite_addr_x,
    output logic [3:0]                              sprite_addr_y,
    input  logic [11:0]                             sprite_pixel,
    // Colour out, two cycles after capture
    output logic [3:0]                              vga_r,
    output logic [3:0]                              vga_g,
    output logic [3:0]                              vga_b
);
    import tetris_render_pkg::*;

    layout_t layout;
    board_if board ();

    board_regs board_regs_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .board   (board.provider)
    );

    screen_layout screen_layout_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .curr_x      (curr_x),
        .curr_y      (curr_y),
        .active_area (active_area),
        .layout      (layout)
    );

    pixel_shader pixel_shader_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .layout        (layout),
        .board         (board.consumer),
        .sprite_addr_x (sprite_addr_x),
        .sprite_addr_y (sprite_addr_y),
        .sprite_pixel  (sprite_pixel),
        .vga_r         (vga_r),
        .vga_g         (vga_g),
        .vga_b         (vga_b)
    );

endmodule

// ==== hdl/pixel_shader.sv ====
`timescale 1ns/1ps

module pixel_shader (
    input  logic                       clk,
    input  logic                       arst_n,
    input  tetris_render_pkg::layout_t layout,
    board_if.consumer                  board,
    output logic [3:0]                 sprite_addr_x,
    output logic [3:0]                 sprite_addr_y,
    input  logic [11:0]                sprite_pixel,
    output logic [3:0]                 vga_r,
    output logic [3:0]                 vga_g,
    output logic [3:0]                 vga_b
);
    import tetris_render_pkg::*;

    logic [15:0] next_mask;
    logic [15:0] hold_mask;
    logic [3:0]  mask_idx;
    logic        on_grid_line;
    logic        draw;          // Pixel belongs to a piece block
    rgb_t        base;
    rgb_t        color_d;
    rgb_t        rgb_q;

    function automatic rgb_t halve(input rgb_t c);
        return {1'b0, c[11:9], 1'b0, c[7:5], 1'b0, c[3:1]};
    endfunction

    // Skip the hidden spawn rows
    assign board.rd_row = 5'(layout.cell_row + hidden_rows);
    assign board.rd_col = layout.cell_col;

    assign next_mask = shape_mask[board.next_piece];
    assign hold_mask = shape_mask[board.hold_piece];
    assign mask_idx  = {layout.prev_row, layout.prev_col};

    assign on_grid_line = layout.blk_x == 5'd0 || layout.blk_x == 5'(block_size - 1) ||
                          layout.blk_y == 5'd0 || layout.blk_y == 5'(block_size - 1);

    always_comb begin
        base = black;
        draw = 1'b0;
        if (layout.valid) begin
            case (layout.region)
                region_border: base = white;
                region_field: begin
                    if (on_grid_line) begin
                        base = grid_grey;
                    end
                    // A filled cell covers the grid lines
                    if (board.cell_code != empty_code) begin
                        draw = 1'b1;
                        base = board.game_over ? over_grey : piece_color[board.cell_code];
                    end
                end
                region_next_header: base = white;
                region_next_body: begin
                    if (layout.prev_in && next_mask[mask_idx]) begin
                        draw = 1'b1;
                        base = piece_color[board.next_piece];
                    end
                end
                region_hold_header: base = board.hold_used ? used_grey : cyan;
                region_hold_body: begin
                    if (board.hold_piece != empty_code && layout.prev_in &&
                        hold_mask[mask_idx]) begin
                        draw = 1'b1;
                        base = board.hold_used ? used_grey : piece_color[board.hold_piece];
                    end
                end
                default: base = black;
            endcase
        end
    end

    // Sprite is 16x16, one texel per 2x2 screen pixels
    assign sprite_addr_x = draw ? layout.blk_x[4:1] : 4'd0;
    assign sprite_addr_y = draw ? layout.blk_y[4:1] : 4'd0;

    // Dim the block where the sprite intensity is not full
    assign color_d = (draw && sprite_pixel[7:4] != 4'hF) ? halve(base) : base;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb_q <= black;
        end else begin
            rgb_q <= color_d;
        end
    end

    assign vga_r = rgb_q[11:8];
    assign vga_g = rgb_q[7:4];
    assign vga_b = rgb_q[3:0];

    // Headers, border and background never fetch sprite texels
    a_sprite_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !(layout.region inside {region_field, region_next_body, region_hold_body}) |->
            sprite_addr_x == 4'd0 && sprite_addr_y == 4'd0);

endmodule

// ==== hdl/screen_layout.sv ====
`timescale 1ns/1ps

module screen_layout (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [10:0]                curr_x,
    input  logic [9:0]                 curr_y,
    input  logic                       active_area,
    output tetris_render_pkg::layout_t layout
);
    import tetris_render_pkg::*;

    logic [10:0] x_q;
    logic [9:0]  y_q;
    logic        act_q;
    logic        in_valid_q;
    logic [31:0] px;
    logic [31:0] py;
    logic [31:0] org_x;
    logic [31:0] org_y;
    logic [31:0] dx;
    logic [31:0] dy;
    region_t     region_d;
    layout_t     lay_d;

    // Coordinate capture
    always_ff @(posedge clk) begin
        x_q <= curr_x;
        y_q <= curr_y;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_q      <= 1'b0;
            in_valid_q <= 1'b0;
        end else begin
            act_q      <= active_area;
            in_valid_q <= 1'b1;   // No stalls, a pixel every cycle
        end
    end

    assign px = 32'(x_q);
    assign py = 32'(y_q);

    // Field box wins over the preview boxes
    always_comb begin
        region_d = region_none;
        if (act_q && px < h_active && py < v_active) begin
            if (px >= grid_x_start - border_w && px < grid_x_start + grid_w + border_w &&
                py >= grid_y_start - border_w && py < grid_y_start + grid_h + border_w) begin
                if (px >= grid_x_start && px < grid_x_start + grid_w &&
                    py >= grid_y_start && py < grid_y_start + grid_h) begin
                    region_d = region_field;
                end else begin
                    region_d = region_border;
                end
            end else if (px >= next_x_start && px < next_x_start + box_size &&
                         py >= grid_y_start && py < grid_y_start + box_size) begin
                region_d = (py < grid_y_start + header_h) ? region_next_header
                                                          : region_next_body;
            end else if (px >= hold_x_start && px < hold_x_start + box_size &&
                         py >= grid_y_start && py < grid_y_start + box_size) begin
                region_d = (py < grid_y_start + header_h) ? region_hold_header
                                                          : region_hold_body;
            end
        end
    end

    // Origin of the block grid for this region
    always_comb begin
        org_x = grid_x_start;
        org_y = grid_y_start;
        if (region_d == region_next_body) begin
            org_x = next_x_start + piece_x_off;
            org_y = grid_y_start + piece_y_off;
        end else if (region_d == region_hold_body) begin
            org_x = hold_x_start + piece_x_off;
            org_y = grid_y_start + piece_y_off;
        end
    end

    assign dx = px - org_x;   // Wraps large when left of the origin
    assign dy = py - org_y;

    always_comb begin
        lay_d          = '0;
        lay_d.valid    = in_valid_q;
        lay_d.region   = region_d;
        lay_d.cell_row = dy[9:5];
        lay_d.cell_col = dx[8:5];
        lay_d.blk_x    = dx[4:0];
        lay_d.blk_y    = dy[4:0];
        lay_d.prev_in  = dx < 4 * block_size && dy < 4 * block_size;
        lay_d.prev_row = dy[6:5];
        lay_d.prev_col = dx[6:5];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            layout <= '0;
        end else begin
            layout <= lay_d;
        end
    end

endmodule

// ==== hdl/board_regs.sv ====
`timescale 1ns/1ps

module board_regs (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic [tetris_render_pkg::apb_addr_w-1:0] paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [31:0]                             pwdata,
    output logic [31:0]                             prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    board_if.provider                               board
);
    import tetris_render_pkg::*;

    piece_t                  cells [field_rows][field_cols];
    piece_t                  next_q;
    piece_t                  hold_q;
    logic                    hold_used_q;
    logic                    game_over_q;
    logic [apb_addr_w-3:0]   word;
    logic [4:0]              acc_row;
    logic [3:0]              acc_col;
    logic                    cell_hit;
    logic                    status_hit;
    logic                    access;
    logic                    wr_en;
    logic [31:0]             status_rd;

    assign word    = paddr[apb_addr_w-1:2];
    assign acc_row = word[8:4];
    assign acc_col = word[3:0];

    assign cell_hit   = int'(acc_row) < field_rows && int'(acc_col) < field_cols;
    assign status_hit = word == status_word;
    assign access     = psel && penable;
    assign wr_en      = access && pwrite;

    assign status_rd = {22'd0, game_over_q, hold_used_q, 1'b0, hold_q, 1'b0, next_q};

    // Zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !(cell_hit || status_hit);

    always_comb begin
        prdata = 32'd0;            // Unmapped reads return zero
        if (cell_hit) begin
            prdata = {29'd0, cells[acc_row][acc_col]};
        end else if (status_hit) begin
            prdata = status_rd;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < field_rows; r++) begin
                for (int c = 0; c < field_cols; c++) begin
                    cells[r][c] <= empty_code;
                end
            end
        end else if (wr_en && cell_hit) begin
            cells[acc_row][acc_col] <= pwdata[2:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_q      <= empty_code;
            hold_q      <= empty_code;
            hold_used_q <= 1'b0;
            game_over_q <= 1'b0;
        end else if (wr_en && status_hit) begin
            next_q      <= pwdata[2:0];
            hold_q      <= pwdata[6:4];
            hold_used_q <= pwdata[8];
            game_over_q <= pwdata[9];
        end
    end

    // Out-of-range shader reads return empty
    assign board.cell_code = (int'(board.rd_row) < field_rows && int'(board.rd_col) < field_cols)
                           ? cells[board.rd_row][board.rd_col] : empty_code;
    assign board.next_piece = next_q;
    assign board.hold_piece = hold_q;
    assign board.hold_used  = hold_used_q;
    assign board.game_over  = game_over_q;

    // An error is only reported in an access that followed its setup cycle
    a_err_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> penable && $past(psel) && !$past(penable));

    // Errored writes leave the previews and flags alone
    a_err_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        (pslverr && pwrite) |=> $stable({next_q, hold_q, hold_used_q, game_over_q}));

endmodule

// ==== hdl/board_if.sv ====
`timescale 1ns/1ps

interface board_if;
    import tetris_render_pkg::*;

    logic [4:0] rd_row;     // Field row incl. hidden rows
    logic [3:0] rd_col;
    piece_t     cell_code;  // Combinational read data
    piece_t     next_piece;
    piece_t     hold_piece;
    logic       hold_used;
    logic       game_over;

    modport provider (
        input  rd_row, rd_col,
        output cell_code, next_piece, hold_piece, hold_used, game_over
    );

    modport consumer (
        output rd_row, rd_col,
        input  cell_code, next_piece, hold_piece, hold_used, game_over
    );

endinterface

// ==== hdl/tetris_render_pkg.sv ====
package tetris_render_pkg;

    // Display mode and field geometry
    localparam int h_active     = 1280;
    localparam int v_active     = 800;
    localparam int block_size   = 32;
    localparam int field_cols   = 10;
    localparam int field_rows   = 22;
    localparam int hidden_rows  = 2;            // Spawn rows, never drawn
    localparam int visible_rows = field_rows - hidden_rows;
    localparam int grid_w       = field_cols * block_size;   // 320
    localparam int grid_h       = visible_rows * block_size; // 640
    localparam int grid_x_start = 480;
    localparam int grid_y_start = 80;
    localparam int border_w     = 4;

    // Preview boxes share the field's top edge
    localparam int next_x_start = 850;
    localparam int hold_x_start = 280;
    localparam int box_size     = 150;
    localparam int header_h     = 20;
    localparam int piece_x_off  = 20;
    localparam int piece_y_off  = 40;

    // APB map, word index is paddr[apb_addr_w-1:2]
    // Cells at row*16+col, status word sits in the unused row 31
    localparam int apb_addr_w = 11;
    localparam logic [apb_addr_w-3:0] status_word = 9'h1F0;

    typedef logic [2:0] piece_t;       // 0..6 = I J L O S T Z
    localparam piece_t empty_code = 3'd7;

    typedef logic [11:0] rgb_t;        // 4 bits each of R, G, B

    localparam rgb_t black     = 12'h000;
    localparam rgb_t white     = 12'hFFF;
    localparam rgb_t grid_grey = 12'h222;
    localparam rgb_t over_grey = 12'h666;
    localparam rgb_t used_grey = 12'h555;
    localparam rgb_t cyan      = 12'h0FF;

    localparam rgb_t piece_color [8] = '{
        12'hF00,  // I
        12'h0F0,  // J
        12'h00F,  // L
        12'hFF0,  // O
        12'hF0F,  // S
        12'h0FF,  // T
        12'hFA0,  // Z
        12'h000   // Empty
    };

    // Spawn orientation, bit r*4+c set where the piece covers row r, col c
    localparam logic [15:0] shape_mask [8] = '{
        16'h00F0, // I, full row 1
        16'h0071, // J
        16'h0074, // L
        16'h0066, // O
        16'h0036, // S
        16'h0072, // T
        16'h0063, // Z
        16'h0000  // Empty draws nothing
    };

    typedef enum logic [2:0] {
        region_none,
        region_border,
        region_field,
        region_next_header,
        region_next_body,
        region_hold_header,
        region_hold_body
    } region_t;

    // Stage one result, one pixel
    typedef struct packed {
        logic       valid;
        region_t    region;
        logic [4:0] cell_row;   // Visible row, 0..19
        logic [3:0] cell_col;
        logic [4:0] blk_x;      // Pixel inside the 32x32 block
        logic [4:0] blk_y;
        logic       prev_in;    // Inside the 4x4 preview area
        logic [1:0] prev_row;
        logic [1:0] prev_col;
    } layout_t;

endpackage
